//--- design/exu_pkg.sv
// ------------------------------
// Execute stage package
// Widths, unit and micro-op codes,
// micro-op views and stage records
// ------------------------------
`default_nettype none

package exu_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int XLEN  = 32;                  // Data word
    localparam int REG_W = 5;                   // Register address
    localparam int UOP_W = 5;                   // Micro-op code
    localparam int FU_W  = 4;                   // One-hot unit field

    // Unit bit positions in the fu field
    localparam int FU_ALU = 0;
    localparam int FU_LSU = 1;
    localparam int FU_CFU = 2;
    localparam int FU_CSR = 3;

    // ------------------------------
    // ALU micro-ops
    // ------------------------------
    localparam logic [UOP_W-1:0] ALU_ADD  = 5'b00001;
    localparam logic [UOP_W-1:0] ALU_SUB  = 5'b00010;
    localparam logic [UOP_W-1:0] ALU_XOR  = 5'b00011;
    localparam logic [UOP_W-1:0] ALU_OR   = 5'b00100;
    localparam logic [UOP_W-1:0] ALU_AND  = 5'b00101;
    localparam logic [UOP_W-1:0] ALU_SLL  = 5'b00110;
    localparam logic [UOP_W-1:0] ALU_SRL  = 5'b00111;
    localparam logic [UOP_W-1:0] ALU_SRA  = 5'b01000;
    localparam logic [UOP_W-1:0] ALU_SLT  = 5'b01001;
    localparam logic [UOP_W-1:0] ALU_SLTU = 5'b01010;

    // ------------------------------
    // Control-flow micro-ops
    // ------------------------------
    localparam logic [1:0] CFU_CLS_COND = 2'b00;   // Conditional branch class

    localparam logic [UOP_W-1:0] CFU_BEQ       = 5'b00001;
    localparam logic [UOP_W-1:0] CFU_BNE       = 5'b00010;
    localparam logic [UOP_W-1:0] CFU_BLT       = 5'b00011;
    localparam logic [UOP_W-1:0] CFU_BGE       = 5'b00100;
    localparam logic [UOP_W-1:0] CFU_BLTU      = 5'b00101;
    localparam logic [UOP_W-1:0] CFU_BGEU      = 5'b00110;
    localparam logic [UOP_W-1:0] CFU_JMP       = 5'b10001; // Unconditional jumps
    localparam logic [UOP_W-1:0] CFU_JALI      = 5'b10010;
    localparam logic [UOP_W-1:0] CFU_JALR      = 5'b10100;
    localparam logic [UOP_W-1:0] CFU_TAKEN     = 5'b11001; // Resolved branches
    localparam logic [UOP_W-1:0] CFU_NOT_TAKEN = 5'b11010;

    // LSU flag positions in the micro-op
    localparam int LSU_LOAD  = 4;
    localparam int LSU_STORE = 3;

    // ------------------------------
    // Micro-op views
    // ------------------------------
    typedef struct packed {
        logic [1:0] cls;                        // 00 cond, 10 jump
        logic [2:0] cond;                       // Condition select
    } cfu_view_t;

    typedef struct packed {
        logic       load;
        logic       store;
        logic [2:0] width;                      // Access width
    } lsu_view_t;

    typedef union packed {
        logic [UOP_W-1:0] code;                 // ALU view
        cfu_view_t        cfu;
        lsu_view_t        lsu;
    } uop_u;

    // ------------------------------
    // Stage records
    // ------------------------------
    typedef struct packed {
        logic [REG_W-1:0] rd;                   // Destination
        logic [XLEN-1:0]  opr_a;
        logic [XLEN-1:0]  opr_b;
        logic [XLEN-1:0]  opr_c;
        uop_u             uop;
        logic [FU_W-1:0]  fu;                   // One-hot unit
        logic             trap;                 // Trap from decode
        logic [1:0]       size;                 // Instruction size
        logic [31:0]      instr;
    } s2_instr_t;

    typedef struct packed {
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  opr_a;
        logic [XLEN-1:0]  opr_b;
        uop_u             uop;
        logic [FU_W-1:0]  fu;
        logic             trap;
        logic [1:0]       size;
        logic [31:0]      instr;
    } s3_result_t;

    typedef struct packed {
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  wdata;                // ALU result or zero
        logic             load;
        logic             csr;
    } fwd_t;

endpackage

`default_nettype wire

//--- design/exu_alu.sv
// ------------------------------
// Integer ALU
// Adder, logic ops, shifter and
// the compare flags for branches
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module exu_alu import exu_pkg::*; (
    input  s2_instr_t        i_s2,            // Decoded instruction
    output logic [XLEN-1:0]  o_result,        // Selected ALU result
    output logic [XLEN-1:0]  o_add_result,    // Always a + b
    output logic             o_eq,            // a == b
    output logic             o_lt_signed,     // a < b signed
    output logic             o_lt_unsigned    // a < b unsigned
);

    // ------------------------------
    // Operands
    // ------------------------------
    logic [XLEN-1:0] opr_a;
    logic [XLEN-1:0] opr_b;
    logic [4:0]      shamt;                   // Low bits of b
    logic            fu_alu;                  // ALU unit selected
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;

    assign opr_a  = i_s2.opr_a;
    assign opr_b  = i_s2.opr_b;
    assign shamt  = opr_b[4:0];
    assign fu_alu = i_s2.fu[FU_ALU];

    assign sum  = opr_a + opr_b;              // Shared with LSU and jalr
    assign diff = opr_a - opr_b;

    // ------------------------------
    // Compare flags
    // ------------------------------
    // Always a against b, branches use them too
    assign o_eq          = (opr_a == opr_b);
    assign o_lt_signed   = ($signed(opr_a) < $signed(opr_b));
    assign o_lt_unsigned = (opr_a < opr_b);

    assign o_add_result = sum;

    // ------------------------------
    // Result mux
    // ------------------------------
    always_comb begin
        o_result = '0;                        // Zero outside the ALU
        if (fu_alu) begin
            case (i_s2.uop.code)
                ALU_ADD: begin
                    o_result = sum;
                end
                ALU_SUB: begin
                    o_result = diff;
                end
                ALU_XOR: begin
                    o_result = opr_a ^ opr_b;
                end
                ALU_OR: begin
                    o_result = opr_a | opr_b;
                end
                ALU_AND: begin
                    o_result = opr_a & opr_b;
                end
                ALU_SLL: begin
                    o_result = opr_a << shamt;
                end
                ALU_SRL: begin
                    o_result = opr_a >> shamt;
                end
                ALU_SRA: begin
                    o_result = $signed(opr_a) >>> shamt; // Sign fill
                end
                ALU_SLT: begin
                    o_result = {{(XLEN-1){1'b0}}, o_lt_signed};
                end
                ALU_SLTU: begin
                    o_result = {{(XLEN-1){1'b0}}, o_lt_unsigned};
                end
                default: begin
                    o_result = '0;            // Unknown code
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/exu_branch.sv
// ------------------------------
// Branch resolution
// Conditional branches become taken
// or not-taken, jumps form targets
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module exu_branch import exu_pkg::*; (
    input  s2_instr_t        i_s2,            // Decoded instruction
    input  logic             i_eq,            // Flags from the ALU
    input  logic             i_lt_signed,
    input  logic             i_lt_unsigned,
    input  logic [XLEN-1:0]  i_add_result,    // a + b for jalr
    output uop_u             o_uop,           // Rewritten micro-op
    output logic [XLEN-1:0]  o_target         // Jump or branch target
);

    logic            cfu_cond;                // Conditional branch
    logic            taken;
    logic [XLEN-1:0] raw_target;              // Before bit 0 clear

    assign cfu_cond = i_s2.fu[FU_CFU] && (i_s2.uop.cfu.cls == CFU_CLS_COND);

    // ------------------------------
    // Condition
    // ------------------------------
    always_comb begin
        case (i_s2.uop.code)
            CFU_BEQ:  taken = i_eq;
            CFU_BNE:  taken = !i_eq;
            CFU_BLT:  taken = i_lt_signed;
            CFU_BGE:  taken = !i_lt_signed;
            CFU_BLTU: taken = i_lt_unsigned;
            CFU_BGEU: taken = !i_lt_unsigned;
            default:  taken = 1'b0;
        endcase
    end

    // Jumps keep their code
    always_comb begin
        o_uop = i_s2.uop;
        if (cfu_cond) begin
            o_uop.code = taken ? CFU_TAKEN : CFU_NOT_TAKEN;
        end
    end

    // ------------------------------
    // Target
    // ------------------------------
    always_comb begin
        case (i_s2.uop.code)
            CFU_JALR: raw_target = i_add_result;  // Register relative
            default:  raw_target = i_s2.opr_c;    // Branches and PC relative jumps
        endcase
    end

    assign o_target = {raw_target[XLEN-1:1], 1'b0};

endmodule

`default_nettype wire

//--- design/exu_result_select.sv
// ------------------------------
// Result select
// Builds the stage record per unit,
// inserts trap cause, forwards rd
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module exu_result_select import exu_pkg::*; (
    input  s2_instr_t        i_s2,            // Decoded instruction
    input  logic [XLEN-1:0]  i_alu_result,
    input  logic [XLEN-1:0]  i_add_result,    // LSU address
    input  uop_u             i_cfu_uop,       // Resolved branch code
    input  logic [XLEN-1:0]  i_cfu_target,
    output s3_result_t       o_s3,            // Into the pipe register
    output fwd_t             o_fwd            // Forwarding record
);

    logic            fu_alu;
    logic            fu_lsu;
    logic            fu_cfu;
    logic            fu_csr;
    logic [XLEN-1:0] trap_cause;              // rd zero-extended

    assign fu_alu = i_s2.fu[FU_ALU];
    assign fu_lsu = i_s2.fu[FU_LSU];
    assign fu_cfu = i_s2.fu[FU_CFU];
    assign fu_csr = i_s2.fu[FU_CSR];

    assign trap_cause = {{(XLEN-REG_W){1'b0}}, i_s2.rd};

    // ------------------------------
    // Outgoing record
    // ------------------------------
    always_comb begin
        o_s3.rd    = i_s2.rd;
        o_s3.fu    = i_s2.fu;
        o_s3.trap  = i_s2.trap;
        o_s3.size  = i_s2.size;
        o_s3.instr = i_s2.instr;
        o_s3.uop   = fu_cfu ? i_cfu_uop : i_s2.uop;

        o_s3.opr_a = '0;
        o_s3.opr_b = '0;                      // ALU and CFU leave it zero
        if (fu_alu) begin
            o_s3.opr_a = i_alu_result;
        end else if (fu_lsu) begin
            o_s3.opr_a = i_add_result;        // Address
            o_s3.opr_b = i_s2.opr_c;          // Store data
        end else if (fu_cfu) begin
            o_s3.opr_a = i_cfu_target;
        end else if (fu_csr) begin
            o_s3.opr_a = i_s2.opr_a;          // CSR operands pass on
            o_s3.opr_b = i_s2.opr_c;
        end

        if (i_s2.trap) begin
            o_s3.opr_b = trap_cause;          // Cause overrides operand
        end
    end

    // ------------------------------
    // Forwarding
    // ------------------------------
    assign o_fwd.rd    = i_s2.rd;
    assign o_fwd.wdata = fu_alu ? i_alu_result : '0;
    assign o_fwd.load  = fu_lsu && i_s2.uop.code[LSU_LOAD]
                                && !i_s2.uop.code[LSU_STORE];
    assign o_fwd.csr   = fu_csr;

endmodule

`default_nettype wire

//--- design/exu_pipe_reg.sv
// ------------------------------
// Stage-3 pipeline register
// One entry, valid/busy handshake,
// cleared by flush
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module exu_pipe_reg import exu_pkg::*; (
    input  logic        g_clk,
    input  logic        i_arst_n,             // Async, active low
    input  logic        i_flush,              // Drop the held entry
    input  s3_result_t  i_data,               // From result select
    input  logic        i_valid,
    output logic        o_busy,               // Back to the upstream side
    output s3_result_t  o_data,               // To memory stage
    output logic        o_valid,
    input  logic        i_busy                // Downstream stall
);

    logic load;                               // Entry accepted this edge

    // Full and not being taken
    assign o_busy = o_valid && i_busy;
    assign load   = i_valid && !o_busy;

    // ------------------------------
    // Valid flag
    // ------------------------------
    always_ff @(posedge g_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid <= 1'b0;
        end else if (i_flush) begin
            o_valid <= 1'b0;                  // Offered item dropped too
        end else if (!o_busy) begin
            o_valid <= i_valid;               // Refill or drain
        end
    end

    // ------------------------------
    // Payload
    // ------------------------------
    always_ff @(posedge g_clk) begin
        if (load && !i_flush) begin
            o_data <= i_data;                 // Holds while stalled
        end
    end

endmodule

`default_nettype wire

//--- design/exu_top.sv
// ------------------------------
// Execute stage
// ALU, branch, result select and
// the stage-3 pipeline register
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module exu_top import exu_pkg::*; (
    input  logic        g_clk,
    input  logic        i_arst_n,
    input  logic        i_flush,
    input  s2_instr_t   i_s2,                 // From decode
    input  logic        i_s2_valid,
    output logic        o_s2_busy,
    output fwd_t        o_fwd,                // Forwarding, combinational
    output s3_result_t  o_s3,                 // To memory stage
    output logic        o_s3_valid,
    input  logic        i_s3_busy
);

    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] add_result;
    logic            alu_eq;
    logic            alu_lt_signed;
    logic            alu_lt_unsigned;
    uop_u            cfu_uop;
    logic [XLEN-1:0] cfu_target;
    s3_result_t      n_s3;                    // Next stage record

    // ------------------------------
    // Units
    // ------------------------------
    exu_alu alu_i (
        .i_s2          (i_s2),
        .o_result      (alu_result),
        .o_add_result  (add_result),
        .o_eq          (alu_eq),
        .o_lt_signed   (alu_lt_signed),
        .o_lt_unsigned (alu_lt_unsigned)
    );

    exu_branch branch_i (
        .i_s2          (i_s2),
        .i_eq          (alu_eq),
        .i_lt_signed   (alu_lt_signed),
        .i_lt_unsigned (alu_lt_unsigned),
        .i_add_result  (add_result),
        .o_uop         (cfu_uop),
        .o_target      (cfu_target)
    );

    exu_result_select select_i (
        .i_s2          (i_s2),
        .i_alu_result  (alu_result),
        .i_add_result  (add_result),
        .i_cfu_uop     (cfu_uop),
        .i_cfu_target  (cfu_target),
        .o_s3          (n_s3),
        .o_fwd         (o_fwd)
    );

    // ------------------------------
    // Pipeline register
    // ------------------------------
    exu_pipe_reg pipe_reg_i (
        .g_clk    (g_clk),
        .i_arst_n (i_arst_n),
        .i_flush  (i_flush),
        .i_data   (n_s3),
        .i_valid  (i_s2_valid),
        .o_busy   (o_s2_busy),
        .o_data   (o_s3),
        .o_valid  (o_s3_valid),
        .i_busy   (i_s3_busy)
    );

endmodule

`default_nettype wire

//--- sim/exu_checker.sv
// ------------------------------
// Execute stage checker
// Compares output records, the handshake
// and the forwarding record with expectations
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module exu_checker import exu_pkg::*; (
    input  logic        g_clk,
    input  logic        i_arst_n,
    input  logic        i_flush,              // Stage flush
    input  logic        i_s2_valid,           // Upstream offer
    input  logic        i_s2_busy,            // DUT busy to upstream
    input  logic        i_push,               // Expected record valid
    input  s3_result_t  i_exp,
    input  logic        i_fwd_chk,            // Compare forwarding now
    input  fwd_t        i_fwd_exp,
    input  fwd_t        i_fwd,                // DUT forwarding
    input  s3_result_t  i_s3,                 // DUT output record
    input  logic        i_s3_valid,
    input  logic        i_s3_busy,
    input  logic        i_done,               // End of stimulus
    output int          o_pending,
    output int          o_errors
);

    s3_result_t exp_q[$];                     // Records still due
    s3_result_t exp_rec;
    int         n_taken;
    logic       reported;
    logic       exp_full;                     // Stage should hold an item

    // ------------------------------
    // Output side
    // ------------------------------
    always @(posedge g_clk) begin
        if (!i_arst_n) begin
            o_pending = 0;
            o_errors  = 0;
            n_taken   = 0;
            reported  = 1'b0;
            exp_full  = 1'b0;                 // Empty after reset
        end else begin
            // Handshake
            if (i_s3_valid !== exp_full) begin
                $display("Mismatch at %0t: output valid got %b expected %b",
                         $time, i_s3_valid, exp_full);
                o_errors = o_errors + 1;
            end
            if (i_s2_busy !== (exp_full && i_s3_busy)) begin
                $display("Mismatch at %0t: busy got %b expected %b",
                         $time, i_s2_busy, exp_full && i_s3_busy);
                o_errors = o_errors + 1;
            end
            if (i_s3_valid && !i_s3_busy) begin     // Transfer on this edge
                if (exp_q.size() == 0) begin
                    $display("Unexpected output record at %0t, nothing was due", $time);
                    o_errors = o_errors + 1;
                end else begin
                    exp_rec = exp_q.pop_front();
                    if (i_s3 !== exp_rec) begin
                        $display("Mismatch at %0t: record %0d got %h expected %h",
                                 $time, n_taken, i_s3, exp_rec);
                        o_errors = o_errors + 1;
                    end
                    n_taken = n_taken + 1;
                end
            end
            if (i_push) begin
                exp_q.push_back(i_exp);             // Accepted this edge
            end
            if (i_fwd_chk && (i_fwd !== i_fwd_exp)) begin
                $display("Mismatch at %0t: forwarding got %h expected %h",
                         $time, i_fwd, i_fwd_exp);
                o_errors = o_errors + 1;
            end
            if (i_done && !reported) begin
                reported = 1'b1;
                if (exp_q.size() != 0) begin
                    $display("Missing outputs: %0d expected records never arrived",
                             exp_q.size());
                    o_errors = o_errors + exp_q.size();
                end
            end
            // Held while stalled, refilled or drained otherwise
            if (i_flush) begin
                exp_full = 1'b0;
            end else if (!(exp_full && i_s3_busy)) begin
                exp_full = i_s2_valid;
            end
            o_pending = exp_q.size();
        end
    end

endmodule

`default_nettype wire

//--- sim/exu_tb.sv
// ------------------------------
// Execute stage testbench
// Table driven stimulus with random
// back-pressure and a flush case
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module exu_tb import exu_pkg::*; ;

    localparam int MAX_ENT = 32;
    localparam int TIMEOUT = 50;              // Cycles per wait

    logic       g_clk;
    logic       i_arst_n;
    logic       i_flush;
    s2_instr_t  i_s2;
    logic       i_s2_valid;
    logic       o_s2_busy;
    fwd_t       o_fwd;
    s3_result_t o_s3;
    logic       o_s3_valid;
    logic       i_s3_busy;

    // Checker side
    logic       push;
    s3_result_t exp_rec;
    logic       fwd_chk;
    fwd_t       fwd_exp;
    logic       done;
    int         pending;
    int         chk_errors;

    // Stimulus table
    s2_instr_t  tab_s2[MAX_ENT];
    s3_result_t tab_exp[MAX_ENT];
    fwd_t       tab_fwd[MAX_ENT];
    logic       tab_flush[MAX_ENT];       // Entry is flushed away
    int         n_ent;

    integer      seed;
    logic [31:0] rnd;
    logic        random_bp;                   // Random busy enabled
    logic        busy_hold;
    int          tb_errors;
    int          cnt;
    logic        accepted;
    logic        timed_out;

    exu_top exu_top_i (
        .g_clk      (g_clk),
        .i_arst_n   (i_arst_n),
        .i_flush    (i_flush),
        .i_s2       (i_s2),
        .i_s2_valid (i_s2_valid),
        .o_s2_busy  (o_s2_busy),
        .o_fwd      (o_fwd),
        .o_s3       (o_s3),
        .o_s3_valid (o_s3_valid),
        .i_s3_busy  (i_s3_busy)
    );

    exu_checker checker_i (
        .g_clk      (g_clk),
        .i_arst_n   (i_arst_n),
        .i_flush    (i_flush),
        .i_s2_valid (i_s2_valid),
        .i_s2_busy  (o_s2_busy),
        .i_push     (push),
        .i_exp      (exp_rec),
        .i_fwd_chk  (fwd_chk),
        .i_fwd_exp  (fwd_exp),
        .i_fwd      (o_fwd),
        .i_s3       (o_s3),
        .i_s3_valid (o_s3_valid),
        .i_s3_busy  (i_s3_busy),
        .i_done     (done),
        .o_pending  (pending),
        .o_errors   (chk_errors)
    );

    always #50 g_clk = ~g_clk;                // 100 ns period

    // ------------------------------
    // Table and cycle helpers
    // ------------------------------
    task automatic add_entry(input logic [4:0] rd, input logic [31:0] a, input logic [31:0] b,
                             input logic [31:0] c, input logic [4:0] uop, input logic [3:0] fu,
                             input logic trap, input logic [31:0] ea, input logic [31:0] eb,
                             input logic [4:0] euop, input logic [31:0] fw, input logic fl,
                             input logic fc, input logic fflush);
        s2_instr_t  s;
        s3_result_t e;
        fwd_t       f;
        s.rd = rd;
        s.opr_a = a;
        s.opr_b = b;
        s.opr_c = c;
        s.uop.code = uop;
        s.fu = fu;
        s.trap = trap;
        s.size = 2'b11;                       // Full size instruction
        s.instr = 32'h1000_0000 + n_ent;
        e.rd = rd;
        e.opr_a = ea;
        e.opr_b = eb;
        e.uop.code = euop;
        e.fu = fu;
        e.trap = trap;
        e.size = s.size;
        e.instr = s.instr;
        f.rd = rd;
        f.wdata = fw;
        f.load = fl;
        f.csr = fc;
        tab_s2[n_ent] = s;
        tab_exp[n_ent] = e;
        tab_fwd[n_ent] = f;
        tab_flush[n_ent] = fflush;
        n_ent = n_ent + 1;
    endtask

    // Advance one cycle and drive 1 ns after the edge
    task automatic next_cycle();
        @(posedge g_clk);
        #1;
        push = 1'b0;
        if (random_bp) begin
            rnd = $random(seed);
            i_s3_busy = rnd[0];
        end else begin
            i_s3_busy = busy_hold;
        end
    endtask

    task automatic fill_table();
        // ALU results in opr_a
        add_entry(5'd1, 32'd5, 32'd7, 32'd0, ALU_ADD, 4'b0001, 0, 32'd12, 0, ALU_ADD,
                  32'd12, 0, 0, 0);
        add_entry(5'd2, 32'd5, 32'd7, 32'd0, ALU_SUB, 4'b0001, 0, 32'hFFFF_FFFE, 0, ALU_SUB,
                  32'hFFFF_FFFE, 0, 0, 0);
        add_entry(5'd3, 32'hF0F0_00FF, 32'h0FF0_0F0F, 0, ALU_XOR, 4'b0001, 0, 32'hFF00_0FF0, 0,
                  ALU_XOR, 32'hFF00_0FF0, 0, 0, 0);
        add_entry(5'd4, 32'hF0F0_00FF, 32'h0FF0_0F0F, 0, ALU_OR, 4'b0001, 0, 32'hFFF0_0FFF, 0,
                  ALU_OR, 32'hFFF0_0FFF, 0, 0, 0);
        add_entry(5'd5, 32'hF0F0_00FF, 32'h0FF0_0F0F, 0, ALU_AND, 4'b0001, 0, 32'h00F0_000F, 0,
                  ALU_AND, 32'h00F0_000F, 0, 0, 0);
        add_entry(5'd6, 32'd1, 32'h24, 0, ALU_SLL, 4'b0001, 0, 32'h10, 0, ALU_SLL, 32'h10, 0, 0, 0);
        add_entry(5'd7, 32'h8000_0000, 32'd4, 0, ALU_SRL, 4'b0001, 0, 32'h0800_0000, 0, ALU_SRL,
                  32'h0800_0000, 0, 0, 0);
        add_entry(5'd8, 32'h8000_0000, 32'd4, 0, ALU_SRA, 4'b0001, 0, 32'hF800_0000, 0, ALU_SRA,
                  32'hF800_0000, 0, 0, 0);
        add_entry(5'd9, 32'hFFFF_FFFF, 32'd1, 0, ALU_SLT, 4'b0001, 0, 32'd1, 0, ALU_SLT,
                  32'd1, 0, 0, 0);
        add_entry(5'd10, 32'hFFFF_FFFF, 32'd1, 0, ALU_SLTU, 4'b0001, 0, 0, 0, ALU_SLTU, 0, 0, 0, 0);
        // LSU load, LSU store, CSR
        add_entry(5'd11, 32'h1000, 32'h24, 32'hDEAD_BEEF, 5'b10010, 4'b0010, 0, 32'h1024,
                  32'hDEAD_BEEF, 5'b10010, 0, 1, 0, 0);
        add_entry(5'd12, 32'h2000, 32'hFFFF_FFFC, 32'h1234_5678, 5'b01010, 4'b0010, 0, 32'h1FFC,
                  32'h1234_5678, 5'b01010, 0, 0, 0, 0);
        add_entry(5'd13, 32'h300, 32'd0, 32'hABCD, 5'b00001, 4'b1000, 0, 32'h300, 32'hABCD,
                  5'b00001, 0, 0, 1, 0);
        // Conditional branches to 0x4001 which loses bit 0
        add_entry(5'd0, 32'd3, 32'd3, 32'h4001, CFU_BEQ, 4'b0100, 0, 32'h4000, 0, CFU_TAKEN,
                  0, 0, 0, 0);
        add_entry(5'd0, 32'd3, 32'd3, 32'h4001, CFU_BNE, 4'b0100, 0, 32'h4000, 0, CFU_NOT_TAKEN,
                  0, 0, 0, 0);
        add_entry(5'd0, 32'hFFFF_FFFF, 32'd1, 32'h4001, CFU_BLT, 4'b0100, 0, 32'h4000, 0, CFU_TAKEN,
                  0, 0, 0, 0);
        add_entry(5'd0, 32'hFFFF_FFFF, 32'd1, 32'h4001, CFU_BGE, 4'b0100, 0, 32'h4000, 0,
                  CFU_NOT_TAKEN, 0, 0, 0, 0);
        add_entry(5'd0, 32'hFFFF_FFFF, 32'd1, 32'h4001, CFU_BLTU, 4'b0100, 0, 32'h4000, 0,
                  CFU_NOT_TAKEN, 0, 0, 0, 0);
        add_entry(5'd0, 32'hFFFF_FFFF, 32'd1, 32'h4001, CFU_BGEU, 4'b0100, 0, 32'h4000, 0, CFU_TAKEN,
                  0, 0, 0, 0);
        // Jumps keep their code
        add_entry(5'd1, 0, 0, 32'h8003, CFU_JMP, 4'b0100, 0, 32'h8002, 0, CFU_JMP, 0, 0, 0, 0);
        add_entry(5'd1, 0, 0, 32'h9001, CFU_JALI, 4'b0100, 0, 32'h9000, 0, CFU_JALI, 0, 0, 0, 0);
        add_entry(5'd1, 32'h5000, 32'd7, 0, CFU_JALR, 4'b0100, 0, 32'h5006, 0, CFU_JALR,
                  0, 0, 0, 0);
        // Trap cause is rd followed by a flushed entry and one after it
        add_entry(5'd7, 32'd1, 32'd2, 0, ALU_ADD, 4'b0001, 1, 32'd3, 32'd7, ALU_ADD,
                  32'd3, 0, 0, 0);
        add_entry(5'd9, 32'd9, 32'd9, 0, ALU_ADD, 4'b0001, 0, 32'd18, 0, ALU_ADD, 32'd18, 0, 0, 1);
        add_entry(5'd3, 32'd10, 32'd20, 0, ALU_ADD, 4'b0001, 0, 32'd30, 0, ALU_ADD,
                  32'd30, 0, 0, 0);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        g_clk = 1'b0;
        i_arst_n = 1'b0;
        i_flush = 1'b0;
        i_s2 = '0;
        i_s2_valid = 1'b0;
        i_s3_busy = 1'b0;
        push = 1'b0;
        exp_rec = '0;
        fwd_chk = 1'b0;
        fwd_exp = '0;
        done = 1'b0;
        seed = 32'he634;
        random_bp = 1'b1;
        busy_hold = 1'b0;
        tb_errors = 0;
        timed_out = 1'b0;
        n_ent = 0;
        fill_table();

        repeat (5) @(posedge g_clk);          // Reset for 5 cycles
        #1;
        i_arst_n = 1'b1;

        for (int i = 0; i < n_ent && !timed_out; i++) begin
            if (tab_flush[i]) begin           // Drain, then stall output
                random_bp = 1'b0;
                busy_hold = 1'b0;
                cnt = 0;
                while (o_s3_valid && cnt < TIMEOUT) begin
                    next_cycle();
                    cnt = cnt + 1;
                end
                if (o_s3_valid) begin
                    $display("Timeout: stage did not drain before entry %0d", i);
                    tb_errors = tb_errors + 1;
                    timed_out = 1'b1;
                end
                busy_hold = 1'b1;
                i_s3_busy = 1'b1;
            end
            i_s2 = tab_s2[i];
            i_s2_valid = 1'b1;
            fwd_exp = tab_fwd[i];
            fwd_chk = 1'b1;
            accepted = 1'b0;
            cnt = 0;
            while (!accepted && !timed_out && cnt < TIMEOUT) begin
                @(negedge g_clk);             // Sample mid cycle where inputs are stable
                if (!o_s2_busy) begin
                    accepted = 1'b1;
                    if (!tab_flush[i]) begin
                        exp_rec = tab_exp[i];
                        push = 1'b1;
                    end
                end
                next_cycle();
                cnt = cnt + 1;
            end
            if (!accepted && !timed_out) begin
                $display("Timeout: entry %0d was never accepted", i);
                tb_errors = tb_errors + 1;
                timed_out = 1'b1;
            end
            i_s2_valid = 1'b0;
            fwd_chk = 1'b0;
            if (tab_flush[i] && accepted) begin
                i_flush = 1'b1;               // Clears on the next edge
                next_cycle();
                i_flush = 1'b0;
                random_bp = 1'b1;
            end
        end

        // Let the output drain
        random_bp = 1'b0;
        busy_hold = 1'b0;
        cnt = 0;
        while ((pending != 0 || o_s3_valid) && cnt < TIMEOUT) begin
            next_cycle();
            cnt = cnt + 1;
        end
        if (pending != 0 || o_s3_valid) begin
            $display("Timeout: output records still pending at the end");
            tb_errors = tb_errors + 1;
        end
        done = 1'b1;
        next_cycle();
        next_cycle();

        $display("Errors: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
design/exu_pkg.sv
design/exu_alu.sv
design/exu_branch.sv
design/exu_result_select.sv
design/exu_pipe_reg.sv
design/exu_top.sv
sim/exu_checker.sv
sim/exu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the execute stage testbench with Verilator, run it and check the log

rm -rf obj_dir sim.log && \
verilator --binary --timing --top-module exu_tb -f flist.f --Mdir obj_dir -o exu_sim && \
./obj_dir/exu_sim > sim.log 2>&1 || { echo "Build or run failed"; exit 1; }

cat sim.log

grep -q "ALL TESTS PASSED" sim.log && echo "Simulation passed" || {
    echo "Simulation failed"
    exit 1
}
